// ==== sources.f ====
+incdir+include
source/rv32i_pkg.sv
source/rv32i_alu.sv
source/rv32i_data_mem.sv
source/rv32i_regfile.sv
source/rv32i_decoder.sv
source/rv32i_exec_stage.sv
source/rv32i_core.sv
tb/tb_rv32i_core.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - files:
      - source/rv32i_pkg.sv
      - source/rv32i_alu.sv
      - source/rv32i_data_mem.sv
      - source/rv32i_regfile.sv
      - source/rv32i_decoder.sv
      - source/rv32i_exec_stage.sv
      - source/rv32i_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_rv32i_core.sv

// ==== include/rv32i_ref_model.svh ====
`ifndef RV32I_REF_MODEL_SVH
`define RV32I_REF_MODEL_SVH

// ****************************************
// instruction-set model state
// ****************************************
logic [31:0] ref_regs [32];
logic [31:0] ref_mem [64];
logic [31:0] ref_pc;

function automatic void reset_model();
    for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        ref_mem[i] = '0;
    end
    ref_pc = '0;
endfunction

// alt selects SUB over ADD and SRA over SRL
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
    logic [31:0] res;
    case (f3)
        3'd0: res = alt ? x - y : x + y;
        3'd1: res = x << y[4:0];
        3'd2: res = {31'b0, $signed(x) < $signed(y)};
        3'd3: res = {31'b0, x < y};
        3'd4: res = x ^ y;
        3'd5: begin
            if (alt) res = $signed(x) >>> y[4:0];
            else res = x >> y[4:0];
        end
        3'd6: res = x | y;
        default: res = x & y;
    endcase
    return res;
endfunction

// executes one instruction on the model and returns its expected retire record
function automatic retire_t step_model(input logic [31:0] ins);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] lane_b;
    logic [31:0] lane_h;
    logic [31:0] val;
    logic        wr;
    logic        legal;
    logic        cond;
    retire_t     r;
    f3 = ins[14:12];
    f7 = ins[31:25];
    rd = ins[11:7];
    a = ref_regs[ins[19:15]];
    b = ref_regs[ins[24:20]];
    imm_i = $signed(ins[31:20]);
    imm_s = $signed({ins[31:25], ins[11:7]});
    imm_b = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0});
    imm_j = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0});
    r = '0;
    r.pc = ref_pc;
    r.next_pc = ref_pc + 32'd4;
    legal = 1'b1;
    wr = 1'b1;
    val = '0;
    case (ins[6:0])
        7'h37: val = {ins[31:12], 12'h000};
        7'h17: val = ref_pc + {ins[31:12], 12'h000};
        7'h6f: begin
            val = ref_pc + 32'd4;
            r.next_pc = ref_pc + imm_j;
        end
        7'h67: begin
            legal = (f3 == 3'd0);
            val = ref_pc + 32'd4;
            r.next_pc = (a + imm_i) & ~32'd1;
        end
        7'h63: begin
            wr = 1'b0;
            cond = 1'b0;
            case (f3)
                3'd0: cond = (a == b);
                3'd1: cond = (a != b);
                3'd4: cond = ($signed(a) < $signed(b));
                3'd5: cond = ($signed(a) >= $signed(b));
                3'd6: cond = (a < b);
                3'd7: cond = (a >= b);
                default: legal = 1'b0;
            endcase
            if (cond) r.next_pc = ref_pc + imm_b;
        end
        7'h03: begin
            addr = a + imm_i;
            word = ref_mem[addr[7:2]];              // only bits 7:2 pick the word
            lane_b = word >> {addr[1:0], 3'b000};
            lane_h = word >> {addr[1], 4'b0000};
            case (f3)
                3'd0: val = {{24{lane_b[7]}}, lane_b[7:0]};
                3'd1: val = {{16{lane_h[15]}}, lane_h[15:0]};
                3'd2: val = word;
                3'd4: val = {24'b0, lane_b[7:0]};
                3'd5: val = {16'b0, lane_h[15:0]};
                default: legal = 1'b0;
            endcase
        end
        7'h23: begin
            wr = 1'b0;
            r.mem_we = 1'b1;
            addr = a + imm_s;
            word = ref_mem[addr[7:2]];
            case (f3)
                3'd0: word = (word & ~(32'hff << {addr[1:0], 3'b000}))
                             | ({24'b0, b[7:0]} << {addr[1:0], 3'b000});
                3'd1: word = (word & ~(32'hffff << {addr[1], 4'b0000}))
                             | ({16'b0, b[15:0]} << {addr[1], 4'b0000});
                3'd2: word = b;
                default: legal = 1'b0;
            endcase
            if (legal) ref_mem[addr[7:2]] = word;
        end
        7'h13: begin
            if (f3 == 3'd1) legal = (f7 == 7'h00);
            if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
            val = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
        end
        7'h33: begin
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            val = alu_ref(f3, f7[5], a, b);
        end
        default: legal = 1'b0;
    endcase
    if (!legal) begin
        r.illegal = 1'b1;
        r.next_pc = ref_pc + 32'd4;
        r.mem_we = 1'b0;
        wr = 1'b0;
    end
    if (wr && rd != 5'd0) begin
        ref_regs[rd] = val;
        r.rd = rd;
        r.wdata = val;
    end
    ref_pc = r.next_pc;
    return r;
endfunction

`endif

// ==== tb/tb_rv32i_core.sv ====
`timescale 1ns/100ps

module tb_rv32i_core import rv32i_pkg::*; ();

    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 100;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        retire_valid;
    retire_t     retire;

    logic [31:0] lcg_state;
    retire_t     exp_q [$];
    int          exp_cyc_q [$];     // edge on which each instruction was driven
    int          cyc;
    int          issued;
    int          retired;
    int          value_errors;
    int          other_errors;

    `include "rv32i_ref_model.svh"

    rv32i_core dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ****************************************
    // random instruction source
    // ****************************************
    function automatic logic [31:0] next_random();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state[31:16];                   // the low LCG bits repeat too quickly
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [31:0] ins;
        r1 = next_random();
        r2 = next_random();
        rd = {2'b00, r1[2:0]};                   // x0 to x7 only, so values get reused
        rs1 = {2'b00, r1[5:3]};
        rs2 = {2'b00, r1[8:6]};
        f3 = r1[11:9];
        case (r1[31:16] % 20)
            0: ins = r2;                         // almost always an illegal encoding
            1, 2, 3, 4: begin
                f7 = (r1[12] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
                ins = {f7, rs2, rs1, f3, rd, 7'h33};
            end
            5, 6, 7: begin
                imm12 = r2[11:0];
                if (f3 == 3'd1) imm12 = {7'h00, r2[4:0]};
                if (f3 == 3'd5) imm12 = {(r1[12] ? 7'h20 : 7'h00), r2[4:0]};
                ins = {imm12, rs1, f3, rd, 7'h13};
            end
            8: ins = {r2[19:0], rd, 7'h37};
            9: ins = {r2[19:0], rd, 7'h17};
            10: ins = {r2[19:0], rd, 7'h6f};
            11: ins = {r2[11:0], rs1, 3'd0, rd, 7'h67};
            12, 13, 14: begin
                if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 | 3'd4;
                ins = {r2[6:0], rs2, rs1, f3, r2[11:7], 7'h63};
            end
            15, 16: begin
                if (f3 == 3'd3) f3 = 3'd2;
                if (f3 >= 3'd6) f3 = f3 - 3'd2;
                ins = {r2[11:0], rs1, f3, rd, 7'h03};
            end
            default: begin
                f3 = {1'b0, f3[1:0]};
                if (f3 == 3'd3) f3 = 3'd2;
                ins = {r2[11:5], rs2, rs1, f3, r2[4:0], 7'h23};
            end
        endcase
        return ins;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            value_errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    // ****************************************
    // retire checker
    // ****************************************
    always @(negedge clk) begin : check_retire
        retire_t expected;
        int      iss;
        if (retire_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("retire_valid high at %0t with no instruction outstanding", $time);
            end else begin
                expected = exp_q.pop_front();
                iss = exp_cyc_q.pop_front();
                retired++;
                if (cyc != iss + 2) begin
                    other_errors++;
                    $display("retire at %0t came %0d edges after issue, not 2", $time, cyc - iss);
                end
                check_field("retire.illegal", expected.illegal, retire.illegal);
                check_field("retire.pc", expected.pc, retire.pc);
                check_field("retire.next_pc", expected.next_pc, retire.next_pc);
                check_field("retire.rd", expected.rd, retire.rd);
                check_field("retire.wdata", expected.wdata, retire.wdata);
                check_field("retire.mem_we", expected.mem_we, retire.mem_we);
            end
        end else if (exp_q.size() != 0 && cyc >= exp_cyc_q[0] + 2) begin
            other_errors++;
            $display("no retire at %0t for the instruction driven on edge %0d",
                     $time, exp_cyc_q[0]);
            expected = exp_q.pop_front();
            iss = exp_cyc_q.pop_front();
        end
    end

    initial begin : stimulus
        logic [31:0] ins;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        lcg_state = 32'h648d;
        cyc = 0;
        issued = 0;
        retired = 0;
        value_errors = 0;
        other_errors = 0;
        reset_model();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (issued < NUM_INSTR && cyc < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cyc++;
            if (next_random() % 4 != 0) begin    // about three cycles in four carry an instruction
                ins = make_instr();
                instr <= ins;
                instr_valid <= 1'b1;
                exp_q.push_back(step_model(ins));
                exp_cyc_q.push_back(cyc);
                issued++;
            end else begin
                instr_valid <= 1'b0;
            end
        end
        @(posedge clk);
        cyc++;
        instr_valid <= 1'b0;
        while (exp_q.size() != 0 && cyc < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        if (cyc >= TIMEOUT_CYCLES) begin
            other_errors++;
            $display("timeout after %0d cycles with %0d instructions issued", cyc, issued);
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d instructions were issued but never retired", exp_q.size());
        end
        $display("issued %0d, retired %0d, value errors %0d, other errors %0d",
                 issued, retired, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== source/rv32i_core.sv ====
`timescale 1ns/100ps

module rv32i_core import rv32i_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  logic [XLEN-1:0] instr,
    output logic            retire_valid,
    output retire_t         retire
);

    dec_instr_t        dec;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic              rf_we;
    logic [REG_AW-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;

    rv32i_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec         (dec)
    );

    // writes land on the same edge that the next decoded instruction appears
    rv32i_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata)
    );

    rv32i_exec_stage u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// ==== source/rv32i_exec_stage.sv ====
`timescale 1ns/100ps

module rv32i_exec_stage import rv32i_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  dec_instr_t        dec,
    output logic [REG_AW-1:0] rs1,
    output logic [REG_AW-1:0] rs2,
    input  logic [XLEN-1:0]   rs1_data,
    input  logic [XLEN-1:0]   rs2_data,
    output logic              rf_we,
    output logic [REG_AW-1:0] rf_waddr,
    output logic [XLEN-1:0]   rf_wdata,
    output logic              retire_valid,
    output retire_t           retire
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] mem_rdata;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] wb_data;
    logic            taken;
    logic            writes_rd;
    logic            mem_we;
    retire_t         ret_nxt;

    assign rs1      = dec.rs1;
    assign rs2      = dec.rs2;
    assign alu_b    = dec.use_imm ? dec.imm : rs2_data;
    assign pc_plus4 = pc + 32'd4;
    assign pc_imm   = pc + dec.imm;
    assign mem_we   = dec.valid && (dec.op inside {OP_SB, OP_SH, OP_SW});

    rv32i_alu u_alu (
        .op     (dec.op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (alu_res),
        .taken  (taken)
    );

    rv32i_data_mem u_dmem (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (dec.op),
        .addr  (alu_res),
        .wdata (rs2_data),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

    // ****************************************
    // next pc and writeback value
    // ****************************************
    always_comb begin
        next_pc   = pc_plus4;
        wb_data   = alu_res;
        writes_rd = 1'b1;
        case (dec.op)
            OP_LUI:   wb_data = dec.imm;
            OP_AUIPC: wb_data = pc_imm;
            OP_JAL: begin
                wb_data = pc_plus4;
                next_pc = pc_imm;
            end
            OP_JALR: begin
                wb_data = pc_plus4;
                next_pc = {alu_res[XLEN-1:1], 1'b0};
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: wb_data = mem_rdata;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                writes_rd = 1'b0;
                if (taken) next_pc = pc_imm;
            end
            OP_SB, OP_SH, OP_SW, OP_ILLEGAL: writes_rd = 1'b0;
            default: writes_rd = 1'b1;       // remaining codes are ALU operations
        endcase
    end

    assign rf_we    = dec.valid && writes_rd && (dec.rd != '0);
    assign rf_waddr = dec.rd;
    assign rf_wdata = wb_data;

    always_comb begin
        ret_nxt.illegal = (dec.op == OP_ILLEGAL);
        ret_nxt.pc      = pc;
        ret_nxt.next_pc = next_pc;
        ret_nxt.rd      = rf_we ? dec.rd : '0;
        ret_nxt.wdata   = rf_we ? wb_data : '0;
        ret_nxt.mem_we  = mem_we;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= RESET_PC;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= dec.valid;
            if (dec.valid) pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) retire <= ret_nxt;
    end

    // branch and jump offsets from the decoder are always even
    a_next_pc_even: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> !retire.next_pc[0]);

endmodule

// ==== source/rv32i_decoder.sv ====
`timescale 1ns/100ps

module rv32i_decoder import rv32i_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  logic [XLEN-1:0] instr,
    output dec_instr_t      dec
);

    logic [2:0]        f3;
    logic [6:0]        f7;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_s;
    logic [XLEN-1:0]   imm_b;
    logic [XLEN-1:0]   imm_u;
    logic [XLEN-1:0]   imm_j;
    logic [XLEN-1:0]   shamt;
    dec_instr_t        nxt;

    assign f3    = instr[14:12];
    assign f7    = instr[31:25];
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign shamt = {27'b0, instr[24:20]};

    // ****************************************
    // opcode and immediate selection
    // ****************************************
    always_comb begin
        nxt       = '0;
        nxt.valid = 1'b1;
        nxt.op    = OP_ILLEGAL;
        case (instr[6:0])
            MAJ_LUI, MAJ_AUIPC: begin
                nxt.op      = (instr[6:0] == MAJ_LUI) ? OP_LUI : OP_AUIPC;
                nxt.rd      = instr[11:7];
                nxt.use_imm = 1'b1;
                nxt.imm     = imm_u;
            end
            MAJ_JAL: begin
                nxt.op      = OP_JAL;
                nxt.rd      = instr[11:7];
                nxt.use_imm = 1'b1;
                nxt.imm     = imm_j;
            end
            MAJ_JALR: begin
                if (f3 == 3'b000) nxt.op = OP_JALR;
                nxt.rs1     = instr[19:15];
                nxt.rd      = instr[11:7];
                nxt.use_imm = 1'b1;
                nxt.imm     = imm_i;
            end
            MAJ_BRANCH: begin
                case (f3)
                    3'b000:  nxt.op = OP_BEQ;
                    3'b001:  nxt.op = OP_BNE;
                    3'b100:  nxt.op = OP_BLT;
                    3'b101:  nxt.op = OP_BGE;
                    3'b110:  nxt.op = OP_BLTU;
                    3'b111:  nxt.op = OP_BGEU;
                    default: nxt.op = OP_ILLEGAL;
                endcase
                nxt.rs1 = instr[19:15];
                nxt.rs2 = instr[24:20];
                nxt.imm = imm_b;           // compared on registers, imm only feeds the target
            end
            MAJ_LOAD: begin
                case (f3)
                    3'b000:  nxt.op = OP_LB;
                    3'b001:  nxt.op = OP_LH;
                    3'b010:  nxt.op = OP_LW;
                    3'b100:  nxt.op = OP_LBU;
                    3'b101:  nxt.op = OP_LHU;
                    default: nxt.op = OP_ILLEGAL;
                endcase
                nxt.rs1     = instr[19:15];
                nxt.rd      = instr[11:7];
                nxt.use_imm = 1'b1;
                nxt.imm     = imm_i;
            end
            MAJ_STORE: begin
                case (f3)
                    3'b000:  nxt.op = OP_SB;
                    3'b001:  nxt.op = OP_SH;
                    3'b010:  nxt.op = OP_SW;
                    default: nxt.op = OP_ILLEGAL;
                endcase
                nxt.rs1     = instr[19:15];
                nxt.rs2     = instr[24:20];
                nxt.use_imm = 1'b1;
                nxt.imm     = imm_s;
            end
            MAJ_OP_IMM: begin
                nxt.rs1     = instr[19:15];
                nxt.rd      = instr[11:7];
                nxt.use_imm = 1'b1;
                nxt.imm     = imm_i;
                case (f3)
                    3'b000: nxt.op = OP_ADD;
                    3'b010: nxt.op = OP_SLT;
                    3'b011: nxt.op = OP_SLTU;
                    3'b100: nxt.op = OP_XOR;
                    3'b110: nxt.op = OP_OR;
                    3'b111: nxt.op = OP_AND;
                    3'b001: begin
                        if (f7 == 7'b0000000) nxt.op = OP_SLL;
                        nxt.imm = shamt;
                    end
                    default: begin
                        if (f7 == 7'b0000000) nxt.op = OP_SRL;
                        else if (f7 == 7'b0100000) nxt.op = OP_SRA;
                        nxt.imm = shamt;   // bit 30 only picks the shift kind
                    end
                endcase
            end
            MAJ_OP: begin
                nxt.rs1 = instr[19:15];
                nxt.rs2 = instr[24:20];
                nxt.rd  = instr[11:7];
                if (f7 == 7'b0000000) begin
                    case (f3)
                        3'b000:  nxt.op = OP_ADD;
                        3'b001:  nxt.op = OP_SLL;
                        3'b010:  nxt.op = OP_SLT;
                        3'b011:  nxt.op = OP_SLTU;
                        3'b100:  nxt.op = OP_XOR;
                        3'b101:  nxt.op = OP_SRL;
                        3'b110:  nxt.op = OP_OR;
                        default: nxt.op = OP_AND;
                    endcase
                end else if (f7 == 7'b0100000) begin
                    if (f3 == 3'b000) nxt.op = OP_SUB;
                    else if (f3 == 3'b101) nxt.op = OP_SRA;
                end
            end
            default: nxt.op = OP_ILLEGAL;
        endcase
        if (nxt.op == OP_ILLEGAL) begin    // an illegal instruction carries no fields
            nxt       = '0;
            nxt.valid = 1'b1;
            nxt.op    = OP_ILLEGAL;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec <= '0;
        end else if (instr_valid) begin
            dec <= nxt;
        end else begin
            dec.valid <= 1'b0;
        end
    end

    a_dec_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        dec.valid == $past(instr_valid));

endmodule

// ==== source/rv32i_regfile.sv ====
`timescale 1ns/100ps

module rv32i_regfile import rv32i_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [REG_AW-1:0] rs1,
    input  logic [REG_AW-1:0] rs2,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data,
    input  logic              we,
    input  logic [REG_AW-1:0] waddr,
    input  logic [XLEN-1:0]   wdata
);

    logic [XLEN-1:0] regs [NUM_REGS];  // x0 is cleared by reset and never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == '0) |-> (rs1_data == '0));

endmodule

// ==== source/rv32i_data_mem.sv ====
`timescale 1ns/100ps

module rv32i_data_mem import rv32i_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_op_t          op,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wdata,
    input  logic            we,
    output logic [XLEN-1:0] rdata
);

    logic [XLEN-1:0]    mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;
    logic [XLEN-1:0]    word;
    logic [7:0]         byte_lane;
    logic [15:0]        half_lane;

    assign idx       = addr[DMEM_AW+1:2];     // upper address bits are ignored
    assign word      = mem[idx];
    assign byte_lane = word[8*addr[1:0] +: 8];
    assign half_lane = word[16*addr[1] +: 16];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            case (op)
                OP_SB:   mem[idx][8*addr[1:0] +: 8] <= wdata[7:0];
                OP_SH:   mem[idx][16*addr[1] +: 16] <= wdata[15:0];
                OP_SW:   mem[idx] <= wdata;
                default: mem[idx] <= mem[idx];
            endcase
        end
    end

    always_comb begin
        case (op)
            OP_LB:   rdata = {{24{byte_lane[7]}}, byte_lane};
            OP_LH:   rdata = {{16{half_lane[15]}}, half_lane};
            OP_LBU:  rdata = {24'b0, byte_lane};
            OP_LHU:  rdata = {16'b0, half_lane};
            default: rdata = word;
        endcase
    end

endmodule

// ==== source/rv32i_alu.sv ====
`timescale 1ns/100ps

module rv32i_alu import rv32i_pkg::*; (
    input  rv_op_t          op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            taken
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (op)
            OP_ADD, OP_JALR,
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW: result = a + b;   // also the effective address
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLL:  result = a << b[4:0];
            OP_SRL:  result = a >> b[4:0];
            OP_SRA:  result = $signed(a) >>> b[4:0];
            OP_SLT:  result = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, lt_u};
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt_s;
            OP_BGE:  taken = !lt_s;
            OP_BLTU: taken = lt_u;
            OP_BGEU: taken = !lt_u;
            default: result = '0;
        endcase
    end

endmodule

// ==== source/rv32i_pkg.sv ====
package rv32i_pkg;

    // ****************************************
    // sizes
    // ****************************************
    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_AW     = 5;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = 6;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // ****************************************
    // encodings
    // ****************************************
    typedef enum logic [6:0] {
        MAJ_LUI    = 7'b0110111,
        MAJ_AUIPC  = 7'b0010111,
        MAJ_JAL    = 7'b1101111,
        MAJ_JALR   = 7'b1100111,
        MAJ_BRANCH = 7'b1100011,
        MAJ_LOAD   = 7'b0000011,
        MAJ_STORE  = 7'b0100011,
        MAJ_OP_IMM = 7'b0010011,
        MAJ_OP     = 7'b0110011
    } rv_major_t;

    // register and immediate forms share the ALU codes, use_imm tells them apart
    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ILLEGAL
    } rv_op_t;

    typedef struct packed {
        logic              valid;
        rv_op_t            op;
        logic              use_imm;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   imm;
    } dec_instr_t;

    typedef struct packed {
        logic              illegal;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   next_pc;
        logic [REG_AW-1:0] rd;      // zero when nothing is written
        logic [XLEN-1:0]   wdata;
        logic              mem_we;
    } retire_t;

endpackage
